// File: verilog/modred_pkg.sv
package modred_pkg;

	parameter int MODULUS = 503;
	parameter int RES_W = 9;
	parameter int CHUNK_W = 6;
	parameter int FOLD_K = 2 ** RES_W - MODULUS; // 512 is congruent to 9.

	parameter int APB_ADDR_W = 8;
	parameter int APB_DATA_W = 32;

	parameter logic [APB_ADDR_W-1:0] ADDR_OPERAND_BASE = 8'h00; // word n sits at 4 times n.
	parameter logic [APB_ADDR_W-1:0] ADDR_CTRL = 8'h40;
	parameter logic [APB_ADDR_W-1:0] ADDR_STATUS = 8'h44;
	parameter logic [APB_ADDR_W-1:0] ADDR_RESULT = 8'h48;

	// weight of chunk position pos, which is 64 to the power pos reduced mod 503.
	function automatic logic [RES_W-1:0] chunk_weight(input int unsigned pos);
		int unsigned w;
		w = 1;
		for (int unsigned i = 0; i < pos; i++)
			w = (w << CHUNK_W) % MODULUS;
		return RES_W'(w);
	endfunction

	// two folding passes bring any 16-bit sum below 1024 without changing it mod 503.
	function automatic logic [RES_W:0] fold_residue(input logic [15:0] sum);
		logic [RES_W+2:0] once;
		once = (RES_W+3)'(sum[RES_W-1:0])
			+ (RES_W+3)'(sum[15:RES_W]) * (RES_W+3)'(FOLD_K);
		return (RES_W+1)'(once[RES_W-1:0])
			+ (RES_W+1)'(once[RES_W+2:RES_W]) * (RES_W+1)'(FOLD_K);
	endfunction

endpackage

// File: verilog/modred_apb_regs.sv
module modred_apb_regs #(
	parameter int OPERAND_W = 500
) (
	input  logic                              pclk,
	input  logic                              rst_n,
	input  logic                              psel,
	input  logic                              penable,
	input  logic                              pwrite,
	input  logic [modred_pkg::APB_ADDR_W-1:0] paddr,
	input  logic [modred_pkg::APB_DATA_W-1:0] pwdata,
	output logic [modred_pkg::APB_DATA_W-1:0] prdata,
	output logic                              pready,
	output logic                              pslverr,
	output logic [OPERAND_W-1:0]              operand,
	output logic                              start,
	input  logic [modred_pkg::RES_W-1:0]      result,
	input  logic                              result_valid
);

	import modred_pkg::*;

	localparam int N_WORDS = (OPERAND_W + APB_DATA_W - 1) / APB_DATA_W;
	localparam int IDX_W = (N_WORDS > 1) ? $clog2(N_WORDS) : 1;
	localparam logic [APB_DATA_W-1:0] LAST_MASK =
		{APB_DATA_W{1'b1}} >> (N_WORDS * APB_DATA_W - OPERAND_W);

	logic [APB_DATA_W-1:0] words [N_WORDS];
	logic                  access;
	logic                  wr_access;
	logic                  rd_access;
	logic [APB_ADDR_W-1:0] op_offset;
	logic [IDX_W-1:0]      word_idx;
	logic                  hit_operand;
	logic                  hit_ctrl;
	logic                  hit_status;
	logic                  hit_result;
	logic                  mapped;
	logic                  refused;
	logic                  start_req;
	logic [APB_DATA_W-1:0] wr_mask;
	logic                  busy;
	logic                  done;
	logic [RES_W-1:0]      result_q;

	assign access = psel && penable;
	assign wr_access = access && pwrite;
	assign rd_access = access && !pwrite;

	assign op_offset = paddr - ADDR_OPERAND_BASE;
	assign word_idx = op_offset[2 +: IDX_W];
	assign hit_operand = (op_offset[1:0] == 2'b00) && (op_offset[APB_ADDR_W-1:2] < N_WORDS);
	assign hit_ctrl = (paddr == ADDR_CTRL);
	assign hit_status = (paddr == ADDR_STATUS);
	assign hit_result = (paddr == ADDR_RESULT);
	assign mapped = hit_operand || hit_ctrl || hit_status || hit_result;

	// operand and start writes are locked out until the running reduction ends.
	assign refused = pwrite && busy && (hit_operand || (hit_ctrl && pwdata[0]));
	assign start_req = wr_access && hit_ctrl && pwdata[0] && !busy;

	assign pready = 1'b1; // zero wait states.
	assign pslverr = access && (!mapped || refused);

	assign wr_mask = (word_idx == IDX_W'(N_WORDS - 1)) ? LAST_MASK : {APB_DATA_W{1'b1}};

	always_ff @(posedge pclk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < N_WORDS; i++)
				words[i] <= '0;
		end
		else if (wr_access && hit_operand && !busy)
			words[word_idx] <= pwdata & wr_mask; // bits past the operand stay zero.
	end

	always_comb
	begin
		operand = '0;
		for (int i = 0; i < N_WORDS; i++)
			operand = operand | (OPERAND_W'(words[i]) << (i * APB_DATA_W));
	end

	always_ff @(posedge pclk)
	begin
		if (!rst_n)
		begin
			start <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			start <= start_req;
			if (start_req)
			begin
				busy <= 1'b1;
				done <= 1'b0;
			end
			else if (result_valid)
			begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	always_ff @(posedge pclk)
	begin
		if (!rst_n)
			result_q <= '0;
		else if (result_valid)
			result_q <= result;
	end

	always_comb
	begin
		prdata = '0;
		if (rd_access)
		begin
			if (hit_operand)
				prdata = words[word_idx];
			else if (hit_status)
				prdata = APB_DATA_W'({done, busy});
			else if (hit_result)
				prdata = APB_DATA_W'(result_q);
		end
	end

endmodule

// File: verilog/modred_chunk_residue.sv
module modred_chunk_residue #(
	parameter int OPERAND_W = 500,
	localparam int N_CHUNKS = (OPERAND_W + modred_pkg::CHUNK_W - 1) / modred_pkg::CHUNK_W
) (
	input  logic                                pclk,
	input  logic                                rst_n,
	input  logic [OPERAND_W-1:0]                operand,
	input  logic                                start,
	output logic [N_CHUNKS*modred_pkg::RES_W-1:0] residues,
	output logic                                residues_valid
);

	import modred_pkg::*;

	localparam int PAD_W = N_CHUNKS * CHUNK_W;
	localparam int PROD_W = CHUNK_W + RES_W;

	logic [PAD_W-1:0]          padded;
	logic [N_CHUNKS*RES_W-1:0] residues_d;

	assign padded = PAD_W'(operand); // the top chunk is zero filled.

	for (genvar i = 0; i < N_CHUNKS; i++)
	begin : chunk_g
		localparam logic [RES_W-1:0] WEIGHT = chunk_weight(i);

		logic [PROD_W-1:0] product;
		logic [RES_W:0]    folded;

		assign product = PROD_W'(padded[i*CHUNK_W +: CHUNK_W]) * PROD_W'(WEIGHT);
		assign folded = fold_residue(16'(product));

		// folding leaves at most 538, so one subtraction is enough.
		assign residues_d[i*RES_W +: RES_W] = (folded >= MODULUS)
			? RES_W'(folded - (RES_W+1)'(MODULUS))
			: folded[RES_W-1:0];
	end

	always_ff @(posedge pclk)
	begin
		if (start)
			residues <= residues_d;
	end

	always_ff @(posedge pclk)
	begin
		if (!rst_n)
			residues_valid <= 1'b0;
		else
			residues_valid <= start;
	end

endmodule

// File: verilog/modred_sum_fold.sv
module modred_sum_fold #(
	parameter int OPERAND_W = 500,
	localparam int N_CHUNKS = (OPERAND_W + modred_pkg::CHUNK_W - 1) / modred_pkg::CHUNK_W
) (
	input  logic                                  pclk,
	input  logic                                  rst_n,
	input  logic [N_CHUNKS*modred_pkg::RES_W-1:0] residues,
	input  logic                                  residues_valid,
	output logic [modred_pkg::RES_W-1:0]          result,
	output logic                                  result_valid
);

	import modred_pkg::*;

	// number of nodes on tree level lvl, where level 0 holds the chunk residues.
	function automatic int level_count(input int lvl);
		int c;
		c = N_CHUNKS;
		for (int i = 0; i < lvl; i++)
			c = (c + 2) / 3;
		return c;
	endfunction

	function automatic int level_offset(input int lvl);
		int o;
		o = 0;
		for (int i = 0; i < lvl; i++)
			o = o + level_count(i);
		return o;
	endfunction

	function automatic int tree_levels();
		int l;
		l = 0;
		while (level_count(l) > 1)
			l++;
		return l;
	endfunction

	localparam int TREE_LEVELS = tree_levels();
	localparam int TOTAL_NODES = level_offset(TREE_LEVELS) + 1;

	logic [RES_W:0] nodes [TOTAL_NODES]; // all levels side by side, root last.
	logic [RES_W:0] root;
	logic [RES_W:0] trim_a;
	logic [RES_W:0] trim_b;

	for (genvar i = 0; i < N_CHUNKS; i++)
	begin : leaf_g
		assign nodes[i] = (RES_W+1)'(residues[i*RES_W +: RES_W]);
	end

	for (genvar l = 0; l < TREE_LEVELS; l++)
	begin : level_g
		for (genvar j = 0; j < level_count(l + 1); j++)
		begin : node_g
			logic [RES_W:0] legs [3];

			for (genvar k = 0; k < 3; k++)
			begin : leg_g
				if (3 * j + k < level_count(l))
				begin : live_g
					assign legs[k] = nodes[level_offset(l) + 3 * j + k];
				end
				else
				begin : pad_g
					assign legs[k] = '0;
				end
			end

			assign nodes[level_offset(l + 1) + j] =
				fold_residue(16'(legs[0]) + 16'(legs[1]) + 16'(legs[2]));
		end
	end

	assign root = nodes[TOTAL_NODES-1]; // already folded below 1024.

	always_comb
	begin
		trim_a = (root >= MODULUS) ? root - (RES_W+1)'(MODULUS) : root;
		trim_b = (trim_a >= MODULUS) ? trim_a - (RES_W+1)'(MODULUS) : trim_a;
	end

	always_ff @(posedge pclk)
	begin
		if (residues_valid)
			result <= trim_b[RES_W-1:0];
	end

	always_ff @(posedge pclk)
	begin
		if (!rst_n)
			result_valid <= 1'b0;
		else
			result_valid <= residues_valid;
	end

endmodule

// File: verilog/modred_top.sv
module modred_top #(
	parameter int OPERAND_W = 500
) (
	input  logic                              pclk,
	input  logic                              rst_n,
	input  logic                              psel,
	input  logic                              penable,
	input  logic                              pwrite,
	input  logic [modred_pkg::APB_ADDR_W-1:0] paddr,
	input  logic [modred_pkg::APB_DATA_W-1:0] pwdata,
	output logic [modred_pkg::APB_DATA_W-1:0] prdata,
	output logic                              pready,
	output logic                              pslverr
);

	import modred_pkg::*;

	localparam int N_CHUNKS = (OPERAND_W + CHUNK_W - 1) / CHUNK_W;

	logic [OPERAND_W-1:0]      operand;
	logic                      start;
	logic [N_CHUNKS*RES_W-1:0] residues;
	logic                      residues_valid;
	logic [RES_W-1:0]          result;
	logic                      result_valid;

	modred_apb_regs #(
		.OPERAND_W(OPERAND_W)
	) u_regs (
		.pclk         (pclk),
		.rst_n        (rst_n),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.operand      (operand),
		.start        (start),
		.result       (result),
		.result_valid (result_valid)
	);

	modred_chunk_residue #(
		.OPERAND_W(OPERAND_W)
	) u_chunk (
		.pclk           (pclk),
		.rst_n          (rst_n),
		.operand        (operand),
		.start          (start),
		.residues       (residues),
		.residues_valid (residues_valid)
	);

	modred_sum_fold #(
		.OPERAND_W(OPERAND_W)
	) u_sum (
		.pclk           (pclk),
		.rst_n          (rst_n),
		.residues       (residues),
		.residues_valid (residues_valid),
		.result         (result),
		.result_valid   (result_valid)
	);

endmodule

// File: test/clk_gen.sv
module clk_gen (
	output logic pclk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 1ps;

	initial
	begin
		pclk = 1'b0;
		forever
			#5 pclk = ~pclk; // 10 ns period.
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (4) @(posedge pclk);
		@(negedge pclk);
		rst_n = 1'b1; // released on a falling edge, after four sampled edges.
	end

endmodule

// File: test/tb_modred.sv
module tb_modred;

	timeunit 1ns;
	timeprecision 1ps;

	import modred_pkg::*;

	localparam int OPERAND_W = 500;
	localparam int N_WORDS = 16;
	localparam int REF_MOD = 503;
	localparam int N_RANDOM = 20;
	localparam int N_CORNER = 6;
	localparam int N_OPS = N_RANDOM + N_CORNER + 6;
	localparam int CYCLE_LIMIT = 40 * N_OPS + 1000;
	localparam logic [31:0] LAST_WORD_MASK = 32'h000f_ffff; // word 15 keeps 20 bits.
	localparam logic [511:0] OP_MASK = (512'(1) << OPERAND_W) - 512'(1);

	logic        pclk;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	logic        expect_err; // response the current access should get.
	logic [31:0] lcg_state;
	logic        timed_out;
	int          cycle_count;
	int          check_count;
	int          data_errors;
	int          resp_errors;

	clk_gen u_clk (
		.pclk  (pclk),
		.rst_n (rst_n)
	);

	modred_top #(
		.OPERAND_W(OPERAND_W)
	) uut (
		.pclk    (pclk),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	function automatic void note_resp_error(input string msg);
		$display("ERROR %0t: %s", $time, msg);
		resp_errors++;
	endfunction

	assert property (@(posedge pclk) pready)
		else note_resp_error("pready dropped low");

	assert property (@(posedge pclk) disable iff (!rst_n)
		(psel && penable) |-> (pslverr == expect_err))
		else note_resp_error("pslverr does not match the expected response");

	assert property (@(posedge pclk) disable iff (!rst_n)
		(psel && penable && !pwrite && expect_err) |-> (prdata == 32'h0))
		else note_resp_error("a refused read returned nonzero data");

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [511:0] random_operand();
		logic [511:0] r;
		for (int i = 0; i < N_WORDS; i++)
			r[i*32 +: 32] = lcg_next();
		return r & OP_MASK;
	endfunction

	// the wide remainder is the model; the DUT works chunk by chunk.
	function automatic logic [8:0] ref_mod(input logic [511:0] op);
		logic [511:0] r;
		r = op % 512'(REF_MOD);
		return r[8:0];
	endfunction

	task automatic check_equal(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		assert (got === exp)
		else
		begin
			$display("ERROR %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
			data_errors++;
		end
	endtask

	// both access tasks start and end on a falling edge with the bus idle.
	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
		input logic err_exp);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		expect_err = err_exp;
		@(negedge pclk);
		penable = 1'b1;
		@(negedge pclk);
		psel = 1'b0;
		penable = 1'b0;
		expect_err = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, input logic err_exp,
		output logic [31:0] data);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		expect_err = err_exp;
		@(negedge pclk);
		penable = 1'b1;
		#1;
		data = prdata; // settled well before the sampling edge.
		@(negedge pclk);
		psel = 1'b0;
		penable = 1'b0;
		expect_err = 1'b0;
	endtask

	task automatic load_operand(input logic [511:0] op);
		for (int i = 0; i < N_WORDS; i++)
			apb_write(ADDR_OPERAND_BASE + 8'(4 * i), op[i*32 +: 32], 1'b0);
	endtask

	task automatic wait_done();
		logic [31:0] rd;
		rd = 32'h0;
		while (!rd[1])
			apb_read(ADDR_STATUS, 1'b0, rd); // the cycle counter bounds this loop.
	endtask

	task automatic check_result(input logic [511:0] op, input string label);
		logic [31:0] rd;
		apb_read(ADDR_RESULT, 1'b0, rd);
		check_equal($sformatf("result for %s", label), rd, 32'(ref_mod(op)));
	endtask

	task automatic run_reduction(input logic [511:0] op, input string label);
		load_operand(op);
		apb_write(ADDR_CTRL, 32'h1, 1'b0);
		wait_done();
		check_result(op, label);
	endtask

	task automatic check_reset_state();
		logic [31:0] rd;
		apb_read(ADDR_STATUS, 1'b0, rd);
		check_equal("status after reset", rd, 32'h0);
		apb_read(ADDR_RESULT, 1'b0, rd);
		check_equal("result after reset", rd, 32'h0);
		apb_read(ADDR_CTRL, 1'b0, rd);
		check_equal("ctrl after reset", rd, 32'h0);
		for (int i = 0; i < N_WORDS; i++)
		begin
			apb_read(ADDR_OPERAND_BASE + 8'(4 * i), 1'b0, rd);
			check_equal($sformatf("operand word %0d after reset", i), rd, 32'h0);
		end
	endtask

	task automatic check_readback();
		logic [31:0] data [N_WORDS];
		logic [31:0] rd;
		for (int i = 0; i < N_WORDS; i++)
			data[i] = lcg_next();
		data[N_WORDS-1] = data[N_WORDS-1] | ~LAST_WORD_MASK; // unused bits written as ones.
		for (int i = 0; i < N_WORDS; i++)
			apb_write(ADDR_OPERAND_BASE + 8'(4 * i), data[i], 1'b0);
		data[N_WORDS-1] = data[N_WORDS-1] & LAST_WORD_MASK;
		for (int i = 0; i < N_WORDS; i++)
		begin
			apb_read(ADDR_OPERAND_BASE + 8'(4 * i), 1'b0, rd);
			check_equal($sformatf("operand word %0d readback", i), rd, data[i]);
		end
	endtask

	// the starting write's access phase is cycle 0.
	task automatic check_done_timing();
		logic [511:0] op;
		logic [31:0] rd;
		op = random_operand();
		load_operand(op);
		apb_write(ADDR_CTRL, 32'h1, 1'b0);
		apb_read(ADDR_STATUS, 1'b0, rd); // access phase in cycle 2.
		check_equal("status while busy", rd, 32'h1);
		@(negedge pclk);
		apb_read(ADDR_STATUS, 1'b0, rd); // started in cycle 4.
		check_equal("status in the fourth cycle after start", rd, 32'h2);
		check_result(op, "timed operand");
		apb_write(ADDR_CTRL, 32'h1, 1'b0);
		apb_read(ADDR_STATUS, 1'b0, rd);
		check_equal("status after a new start", rd, 32'h1);
		wait_done();
		check_result(op, "restarted operand");
	endtask

	task automatic check_refused();
		logic [511:0] op;
		logic [31:0] rd;
		apb_write(8'h4c, 32'h1234_5678, 1'b1);
		apb_read(8'h80, 1'b1, rd);
		check_equal("unmapped read", rd, 32'h0);
		apb_read(8'h42, 1'b1, rd);
		check_equal("misaligned read", rd, 32'h0);
		op = random_operand();
		load_operand(op);
		apb_write(ADDR_CTRL, 32'h1, 1'b0);
		apb_write(ADDR_OPERAND_BASE, ~op[31:0], 1'b1); // lands while busy.
		wait_done();
		check_result(op, "operand after refused write");
		apb_read(ADDR_OPERAND_BASE, 1'b0, rd);
		check_equal("operand word 0 after refused write", rd, op[31:0]);
		apb_write(ADDR_CTRL, 32'h1, 1'b0);
		apb_write(ADDR_CTRL, 32'h1, 1'b1);
		wait_done();
		check_result(op, "operand after refused start");
	endtask

	task automatic finish_run();
		$display("checks: %0d, data errors: %0d, response errors: %0d",
			check_count, data_errors, resp_errors);
		if (data_errors == 0 && resp_errors == 0 && !timed_out)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	endtask

	initial
	begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT)
		begin
			@(posedge pclk);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d clock cycles.", CYCLE_LIMIT);
		timed_out = 1'b1;
		finish_run();
	end

	initial
	begin
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 8'h0;
		pwdata = 32'h0;
		expect_err = 1'b0;
		timed_out = 1'b0;
		check_count = 0;
		data_errors = 0;
		resp_errors = 0;
		lcg_state = 32'h9a28;
		@(posedge rst_n);
		check_reset_state();
		check_readback();
		for (int n = 0; n < N_RANDOM; n++)
			run_reduction(random_operand(), $sformatf("random operand %0d", n));
		run_reduction(512'd0, "operand zero");
		run_reduction(512'd502, "operand 502");
		run_reduction(512'd503, "operand 503");
		run_reduction(512'd504, "operand 504");
		run_reduction(OP_MASK, "operand all ones");
		run_reduction(512'(1) << (OPERAND_W - 1), "operand top bit");
		check_done_timing();
		check_refused();
		finish_run();
	end

endmodule

// File: compile.f
verilog/modred_pkg.sv
verilog/modred_apb_regs.sv
verilog/modred_chunk_residue.sv
verilog/modred_sum_fold.sv
verilog/modred_top.sv
test/clk_gen.sv
test/tb_modred.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f compile.f --top-module tb_modred -o tb_modred \
	&& ./obj_dir/tb_modred > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -qx "all tests passed" sim.log && exit 0 || exit 1
